// ==== fetch_pkg.sv ====
package fetch_pkg;

    // instruction address as seen by fetch and writeback
    typedef logic [31:0] eip_t;

    // fetch-line address, eip bits 31..4
    typedef logic [27:0] fip_t;

    // bytes per fetch line
    // the sequential path steps by this amount
    localparam eip_t LINE_BYTES = 32'd16;

endpackage

// ==== btb_pkg.sv ====
package btb_pkg;

    // what one entry stores next to its tag
    typedef struct packed {
        // predicted branch target
        fetch_pkg::eip_t target_eip;
        // even line of the target
        fetch_pkg::fip_t fip_e;
        // odd line of the target
        fetch_pkg::fip_t fip_o;
    } btb_payload_t;

    // writeback update, single-cycle strobe
    typedef struct packed {
        logic            valid;
        // full branch address, used as the tag
        fetch_pkg::eip_t branch_eip;
        btb_payload_t    payload;
    } btb_update_t;

    // lookup result for the current fetch eip
    typedef struct packed {
        logic         hit;
        // zero when hit is low
        btb_payload_t payload;
    } btb_lookup_t;

    // entries when the top level sets nothing else
    localparam int unsigned DEFAULT_ENTRIES = 8;

endpackage

// ==== btb_victim_ptr.sv ====
`timescale 1ns/1ps

module btb_victim_ptr #(
    parameter int unsigned NUM_ENTRIES = btb_pkg::DEFAULT_ENTRIES
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   allocate,
    output logic [NUM_ENTRIES-1:0] victim
);

    // one-hot round-robin pointer
    // no counter and no decoder, the register drives the enables directly
    logic [NUM_ENTRIES-1:0] victim_q;
    logic [NUM_ENTRIES-1:0] victim_rot;

    // rotate left by one, top bit wraps to entry 0
    assign victim_rot = {victim_q[NUM_ENTRIES-2:0], victim_q[NUM_ENTRIES-1]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // first allocation after reset goes to entry 0
            victim_q <= {{(NUM_ENTRIES-1){1'b0}}, 1'b1};
        end else if (allocate) begin
            victim_q <= victim_rot;
        end
    end

    // a rewrite of an existing tag leaves the pointer alone
    assign victim = victim_q;

endmodule

// ==== btb_entry_array.sv ====
`timescale 1ns/1ps

module btb_entry_array #(
    parameter int unsigned NUM_ENTRIES = btb_pkg::DEFAULT_ENTRIES
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [NUM_ENTRIES-1:0] write_en,
    input  fetch_pkg::eip_t        write_tag,
    input  btb_pkg::btb_payload_t  write_payload,
    output logic [NUM_ENTRIES-1:0] valid,
    output fetch_pkg::eip_t        tags     [NUM_ENTRIES],
    output btb_pkg::btb_payload_t  payloads [NUM_ENTRIES]
);

    // storage for every entry
    logic [NUM_ENTRIES-1:0] valid_q;
    fetch_pkg::eip_t        tag_q     [NUM_ENTRIES];
    btb_pkg::btb_payload_t  payload_q [NUM_ENTRIES];

    genvar i;
    generate
        for (i = 0; i < NUM_ENTRIES; i = i + 1) begin : g_entry

            // valid bit, only reset clears it
            // no single-entry invalidate
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    valid_q[i] <= 1'b0;
                end else if (write_en[i]) begin
                    valid_q[i] <= 1'b1;
                end
            end

            // tag and payload load together
            // contents are don't-care while valid is low
            always_ff @(posedge clk) begin
                if (write_en[i]) begin
                    tag_q[i]     <= write_tag;
                    payload_q[i] <= write_payload;
                end
            end

            // all entries visible to the compare banks
            assign tags[i]     = tag_q[i];
            assign payloads[i] = payload_q[i];

        end
    endgenerate

    assign valid = valid_q;

endmodule

// ==== btb_tag_match.sv ====
`timescale 1ns/1ps

module btb_tag_match #(
    parameter int unsigned NUM_ENTRIES = btb_pkg::DEFAULT_ENTRIES
) (
    input  fetch_pkg::eip_t        read_tag,
    input  fetch_pkg::eip_t        write_tag,
    input  logic [NUM_ENTRIES-1:0] valid,
    input  fetch_pkg::eip_t        tags     [NUM_ENTRIES],
    input  btb_pkg::btb_payload_t  payloads [NUM_ENTRIES],
    output btb_pkg::btb_lookup_t   lookup,
    output logic [NUM_ENTRIES-1:0] write_hits,
    output logic                   write_hit
);

    localparam int unsigned PAYLOAD_W = $bits(btb_pkg::btb_payload_t);

    // read bank hits, one-hot or zero
    logic [NUM_ENTRIES-1:0] read_hits;
    // and-or select result
    logic [PAYLOAD_W-1:0]   payload_or;

    // two compare banks side by side
    // both qualified by valid so stale tags never match
    genvar i;
    generate
        for (i = 0; i < NUM_ENTRIES; i = i + 1) begin : g_cmp
            assign read_hits[i]  = valid[i] && (tags[i] == read_tag);
            assign write_hits[i] = valid[i] && (tags[i] == write_tag);
        end
    endgenerate

    // one-hot payload select
    // update path never stores a duplicate tag, so at most one term is live
    // a miss leaves every term masked and the result at zero
    always_comb begin
        payload_or = '0;
        for (int unsigned j = 0; j < NUM_ENTRIES; j = j + 1) begin
            payload_or = payload_or | (payloads[j] & {PAYLOAD_W{read_hits[j]}});
        end
    end

    // read side result
    assign lookup.hit     = |read_hits;
    assign lookup.payload = btb_pkg::btb_payload_t'(payload_or);

    // write side, tells the top whether to rewrite or allocate
    assign write_hit = |write_hits;

endmodule

// ==== fetch_pc_gen.sv ====
`timescale 1ns/1ps

module fetch_pc_gen (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall,
    input  logic                 redirect_valid,
    input  fetch_pkg::eip_t      redirect_eip,
    input  btb_pkg::btb_lookup_t prediction,
    output fetch_pkg::eip_t      fetch_eip
);

    fetch_pkg::eip_t fetch_eip_q;
    fetch_pkg::eip_t line_base;
    fetch_pkg::eip_t seq_eip;
    fetch_pkg::eip_t next_eip;

    // start of the current line, low offset bits cleared
    assign line_base = fetch_eip_q & ~(fetch_pkg::LINE_BYTES - 32'd1);
    // next sequential line
    assign seq_eip   = line_base + fetch_pkg::LINE_BYTES;

    // next address select
    // redirect beats stall, stall beats the prediction
    always_comb begin
        if (redirect_valid) begin
            next_eip = redirect_eip;
        end else if (stall) begin
            // hold while downstream is busy
            next_eip = fetch_eip_q;
        end else if (prediction.hit) begin
            next_eip = prediction.payload.target_eip;
        end else begin
            next_eip = seq_eip;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_eip_q <= '0;
        end else begin
            fetch_eip_q <= next_eip;
        end
    end

    // also the read tag of the buffer
    assign fetch_eip = fetch_eip_q;

endmodule

// ==== btb_top.sv ====
`timescale 1ns/1ps

module btb_top #(
    parameter int unsigned NUM_ENTRIES = btb_pkg::DEFAULT_ENTRIES
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  btb_pkg::btb_update_t update,
    input  logic                 redirect_valid,
    input  fetch_pkg::eip_t      redirect_eip,
    input  logic                 stall,
    output fetch_pkg::eip_t      fetch_eip,
    output btb_pkg::btb_lookup_t prediction
);

    // entry array outputs
    logic [NUM_ENTRIES-1:0] valid;
    fetch_pkg::eip_t        tags     [NUM_ENTRIES];
    btb_pkg::btb_payload_t  payloads [NUM_ENTRIES];

    // write side of the compare
    logic [NUM_ENTRIES-1:0] write_hits;
    logic                   write_hit;

    // replacement
    logic [NUM_ENTRIES-1:0] victim;
    logic                   allocate;
    logic [NUM_ENTRIES-1:0] write_en;

    // new tag only, a known tag is rewritten in place
    assign allocate = update.valid && !write_hit;

    // rewrite hits its own entry, else the victim takes it
    assign write_en = !update.valid ? '0 :
                      write_hit     ? write_hits : victim;

    btb_entry_array #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) u_entry_array (
        .clk           (clk),
        .rst_n         (rst_n),
        .write_en      (write_en),
        .write_tag     (update.branch_eip),
        .write_payload (update.payload),
        .valid         (valid),
        .tags          (tags),
        .payloads      (payloads)
    );

    // lookup on the registered fetch eip
    // same-cycle update is not visible yet
    btb_tag_match #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) u_tag_match (
        .read_tag   (fetch_eip),
        .write_tag  (update.branch_eip),
        .valid      (valid),
        .tags       (tags),
        .payloads   (payloads),
        .lookup     (prediction),
        .write_hits (write_hits),
        .write_hit  (write_hit)
    );

    btb_victim_ptr #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) u_victim_ptr (
        .clk      (clk),
        .rst_n    (rst_n),
        .allocate (allocate),
        .victim   (victim)
    );

    fetch_pc_gen u_fetch_pc_gen (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall          (stall),
        .redirect_valid (redirect_valid),
        .redirect_eip   (redirect_eip),
        .prediction     (prediction),
        .fetch_eip      (fetch_eip)
    );

endmodule

// ==== btb_properties.sv ====
`timescale 1ns/1ps

module btb_properties #(
    parameter int unsigned NUM_ENTRIES = btb_pkg::DEFAULT_ENTRIES
) (
    input logic                   clk,
    input logic                   rst_n,
    input logic [NUM_ENTRIES-1:0] write_en,
    input logic [NUM_ENTRIES-1:0] victim,
    input btb_pkg::btb_lookup_t   prediction
);

    // count of failed assertions
    int fail_count = 0;

    // at most one entry written per update
    write_en_onehot0: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(write_en))
    else begin
        fail_count++;
        $error("write enables select more than one entry");
    end

    // round-robin pointer never loses or duplicates its bit
    victim_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot(victim))
    else begin
        fail_count++;
        $error("victim pointer is not one-hot");
    end

    // and-or select must give zero on a miss
    miss_payload_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !prediction.hit |-> (prediction.payload == '0))
    else begin
        fail_count++;
        $error("prediction payload not zero on a miss");
    end

endmodule

bind btb_top btb_properties #(
    .NUM_ENTRIES (NUM_ENTRIES)
) u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .write_en   (write_en),
    .victim     (victim),
    .prediction (prediction)
);

// ==== tb_btb.sv ====
`timescale 1ns/1ps

module tb_btb;

    localparam int N          = 8;
    localparam int CLK_PERIOD = 10;
    localparam int RAND_CYCLES = 2000;
    // reset and the directed tests in order, then the random run
    localparam int TEST_CYCLES = 3 + 11 + 3 + 18 + 11 + 10 + RAND_CYCLES;
    localparam int MARGIN      = 200;

    logic                 clk;
    logic                 rst_n;
    btb_pkg::btb_update_t update;
    logic                 redirect_valid;
    fetch_pkg::eip_t      redirect_eip;
    logic                 stall;
    fetch_pkg::eip_t      fetch_eip;
    btb_pkg::btb_lookup_t prediction;

    // reference model state
    logic                  m_valid   [N];
    fetch_pkg::eip_t       m_tag     [N];
    btb_pkg::btb_payload_t m_payload [N];
    int                    m_victim;
    fetch_pkg::eip_t       m_fetch;

    int checks;
    int errors;
    int tests_run;
    int err_before;
    int seed;
    fetch_pkg::eip_t t3_tags [9];

    btb_top #(
        .NUM_ENTRIES (N)
    ) dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .update         (update),
        .redirect_valid (redirect_valid),
        .redirect_eip   (redirect_eip),
        .stall          (stall),
        .fetch_eip      (fetch_eip),
        .prediction     (prediction)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // tags on consecutive lines so sequential fetch runs into them
    function automatic fetch_pkg::eip_t pool_eip(input logic [3:0] idx);
        return 32'h0000_8000 + 32'(idx) * 32'd16;
    endfunction

    function automatic btb_pkg::btb_update_t make_update(input logic v,
            input fetch_pkg::eip_t tag, input fetch_pkg::eip_t target);
        btb_pkg::btb_update_t u;
        u.valid              = v;
        u.branch_eip         = tag;
        u.payload.target_eip = target;
        // even and odd line pair around the target
        u.payload.fip_e      = {target[31:5], 1'b0};
        u.payload.fip_o      = {target[31:5], 1'b1};
        return u;
    endfunction

    // fully associative search with zero payload on a miss
    function automatic btb_pkg::btb_lookup_t model_lookup(input fetch_pkg::eip_t eip);
        btb_pkg::btb_lookup_t r;
        r = '0;
        for (int k = 0; k < N; k++) begin
            if (m_valid[k] && m_tag[k] == eip) begin
                r.hit     = 1'b1;
                r.payload = m_payload[k];
            end
        end
        return r;
    endfunction

    // known tag rewritten in place and a new tag takes the victim slot
    task automatic model_write(input btb_pkg::btb_update_t upd);
        int slot;
        slot = -1;
        if (upd.valid) begin
            for (int k = 0; k < N; k++) begin
                if (m_valid[k] && m_tag[k] == upd.branch_eip) slot = k;
            end
            if (slot < 0) begin
                slot     = m_victim;
                m_victim = (m_victim + 1) % N;
            end
            m_valid[slot]   = 1'b1;
            m_tag[slot]     = upd.branch_eip;
            m_payload[slot] = upd.payload;
        end
    endtask

    task automatic check_lookup(input btb_pkg::btb_lookup_t got,
            input btb_pkg::btb_lookup_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: lookup at %h got hit=%0b payload=%h, expected hit=%0b payload=%h",
                     $time, m_fetch, got.hit, got.payload, exp.hit, exp.payload);
        end
    endtask

    task automatic check_eip(input fetch_pkg::eip_t got, input fetch_pkg::eip_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: fetch_eip got %h, expected %h", $time, got, exp);
        end
    endtask

    // drive one clock, check mid-cycle and advance the model
    task automatic run_cycle(input btb_pkg::btb_update_t upd, input logic redir,
            input fetch_pkg::eip_t reip, input logic stl);
        btb_pkg::btb_lookup_t exp_lk;
        update         = upd;
        redirect_valid = redir;
        redirect_eip   = reip;
        stall          = stl;
        #4;
        check_eip(fetch_eip, m_fetch);
        exp_lk = model_lookup(m_fetch);
        check_lookup(prediction, exp_lk);
        // priority is redirect then stall then hit then next 16-byte line
        if (redir) m_fetch = reip;
        else if (stl) m_fetch = m_fetch;
        else if (exp_lk.hit) m_fetch = exp_lk.payload.target_eip;
        else m_fetch = (m_fetch & ~32'd15) + 32'd16;
        model_write(upd);
        @(posedge clk);
        #1;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("test %0d %s: %s (%0d errors)", tests_run, name,
                 (errors == err_before) ? "passed" : "failed", errors - err_before);
        err_before = errors;
    endtask

    // watchdog
    initial begin
        #((TEST_CYCLES + MARGIN) * CLK_PERIOD);
        $display("timeout: the tests did not complete within %0d cycles", TEST_CYCLES + MARGIN);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        btb_pkg::btb_update_t idle;
        logic [31:0] r;
        idle = '0;
        clk = 1'b0;
        rst_n = 1'b0;
        update = '0;
        redirect_valid = 1'b0;
        redirect_eip = '0;
        stall = 1'b0;
        seed = 32'h3fd8_b521;
        checks = 0;
        errors = 0;
        tests_run = 0;
        err_before = 0;
        for (int k = 0; k < N; k++) m_valid[k] = 1'b0;
        m_victim = 0;
        m_fetch = '0;
        for (int i = 0; i < 9; i++) t3_tags[i] = 32'h0004_0000 + 32'(i) * 32'h120;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // empty buffer so everything misses
        for (int i = 0; i < 10; i++) run_cycle(idle, 1'b1, 32'h0000_1000 + 32'(i) * 32'h37, 1'b0);
        run_cycle(idle, 1'b0, '0, 1'b1);
        end_test("after reset");

        // a same-cycle write stays invisible until the next cycle
        run_cycle(idle, 1'b1, 32'h0001_2340, 1'b0);
        run_cycle(make_update(1'b1, 32'h0001_2340, 32'h0002_0008), 1'b0, '0, 1'b1);
        run_cycle(idle, 1'b0, '0, 1'b1);
        end_test("write then read");

        // fill all entries and rewrite tag 3 in place
        for (int i = 0; i < 8; i++) begin
            run_cycle(make_update(1'b1, t3_tags[i], 32'h0006_0000 + 32'(i) * 32'h40),
                      1'b0, '0, 1'b1);
        end
        run_cycle(make_update(1'b1, t3_tags[3], 32'h0007_7770), 1'b0, '0, 1'b1);
        for (int i = 0; i < 8; i++) run_cycle(idle, 1'b1, t3_tags[i], 1'b0);
        run_cycle(idle, 1'b0, '0, 1'b1);
        end_test("rewrite");

        // ninth tag evicts the oldest
        run_cycle(make_update(1'b1, t3_tags[8], 32'h0006_0800), 1'b0, '0, 1'b1);
        for (int i = 0; i < 9; i++) run_cycle(idle, 1'b1, t3_tags[i], 1'b0);
        run_cycle(idle, 1'b0, '0, 1'b1);
        end_test("replacement");

        // line steps on a miss and holds on a stall
        // hit jumps to the target and redirect wins over both
        run_cycle(idle, 1'b1, 32'h000a_0003, 1'b0);
        run_cycle(idle, 1'b0, '0, 1'b0);
        run_cycle(idle, 1'b0, '0, 1'b0);
        run_cycle(idle, 1'b0, '0, 1'b1);
        run_cycle(idle, 1'b0, '0, 1'b1);
        run_cycle(idle, 1'b1, t3_tags[3], 1'b0);
        run_cycle(idle, 1'b0, '0, 1'b0);
        run_cycle(idle, 1'b1, t3_tags[4], 1'b0);
        run_cycle(idle, 1'b1, 32'h000a_0100, 1'b1);
        run_cycle(idle, 1'b0, '0, 1'b1);
        end_test("fetch sequencing");

        // random traffic over 16 pool tags on 8 entries
        for (int c = 0; c < RAND_CYCLES; c++) begin
            r = $random(seed);
            run_cycle(make_update(r[2:0] < 3'd3, pool_eip(r[15:12]),
                                  pool_eip(r[19:16]) + 32'(r[23:20])),
                      r[6:4] == 3'd0, pool_eip(r[27:24]) + 32'(r[31:28]),
                      r[9:8] == 2'd0);
        end
        end_test("random mix");

        errors = errors + dut0.u_props.fail_count;
        $display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests_run, checks, errors, dut0.u_props.fail_count);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== project.f ====
fetch_pkg.sv
btb_pkg.sv
btb_victim_ptr.sv
btb_entry_array.sv
btb_tag_match.sv
fetch_pc_gen.sv
btb_top.sv
btb_properties.sv
tb_btb.sv
